// File: hdl/cp0_pkg.sv
// Shared widths, register numbers and instruction encodings for coprocessor 0, imported by each RTL module
package cp0_pkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_addr_t; // Coprocessor 0 register number
    typedef logic [4:0]  exc_code_t; // Cause exception code
    typedef logic [5:0]  irq_t;      // Hardware interrupt lines, Status and Cause bits 15 to 10

    // Coprocessor 0 register numbers handled here
    localparam reg_addr_t CP0_COUNT   = 5'd9;
    localparam reg_addr_t CP0_COMPARE = 5'd11;
    localparam reg_addr_t CP0_SR      = 5'd12;
    localparam reg_addr_t CP0_CAUSE   = 5'd13;
    localparam reg_addr_t CP0_EPC     = 5'd14;

    localparam logic [5:0] OP_COP0    = 6'b010000;
    localparam logic [4:0] RS_MTC0    = 5'b00100;
    localparam logic [4:0] RS_MFC0    = 5'b00000;
    localparam logic [5:0] FUNCT_ERET = 6'b011000; // Also needs the CO bit, instruction bit 25

    localparam exc_code_t EXC_INT = 5'd0;

    localparam int SR_IE_BIT    = 0;
    localparam int SR_EXL_BIT   = 1;
    localparam int CAUSE_BD_BIT = 31;
    localparam int IP_LSB       = 10; // SR mask and Cause pending bits share this field
    localparam int IP_MSB       = 15;
    localparam int EXC_CODE_LSB = 2;
    localparam int CO_BIT       = 25;

    localparam int COUNT_DIV_DEFAULT = 2;

    // Instruction field extraction shared by the decoders
    function automatic logic [5:0] inst_op(input word_t inst);
        return inst[31:26];
    endfunction

    function automatic logic [4:0] inst_rs(input word_t inst);
        return inst[25:21];
    endfunction

    function automatic reg_addr_t inst_rd(input word_t inst);
        return inst[15:11];
    endfunction

    function automatic logic [5:0] inst_funct(input word_t inst);
        return inst[5:0];
    endfunction

endpackage

// File: hdl/cp0_submitter.sv
// Decides exception and interrupt entry, eret and mtc0 for the commit stage and drives the CP0 register updates
`timescale 1ns/1ns

module cp0_submitter import cp0_pkg::*; (
    input  word_t     inst,
    input  word_t     rt,
    input  logic      exception,
    input  word_t     pc,
    input  exc_code_t exc_code,
    input  logic      bd,
    input  irq_t      irq,
    input  word_t     sr,
    input  word_t     cause,
    output logic      branch_to_handler,
    output logic      eret,
    output word_t     new_sr,
    output logic      sr_en,
    output word_t     new_cause,
    output logic      cause_en,
    output word_t     new_epc,
    output logic      epc_en,
    output logic      wr_count,
    output logic      wr_compare
);

    logic      sr_ie;
    logic      sr_exl;
    irq_t      sr_mask;
    irq_t      irq_active;
    logic      irq_pend;
    logic      submit;
    logic      is_cop0;
    logic      is_mtc0;
    logic      is_eret;
    reg_addr_t rd;
    word_t     sr_entry;
    word_t     sr_return;
    word_t     cause_entry;

    assign sr_ie   = sr[SR_IE_BIT];
    assign sr_exl  = sr[SR_EXL_BIT];
    assign sr_mask = sr[IP_MSB:IP_LSB];

    // A line counts only when unmasked, with interrupts on and no handler running
    assign irq_active = irq & sr_mask & {$bits(irq_t){sr_ie & ~sr_exl}};
    assign irq_pend   = |irq_active;

    assign submit = (irq_pend | exception) && (pc != '0); // Bubbles carry a zero PC

    assign is_cop0 = inst_op(inst) == OP_COP0;
    assign is_mtc0 = is_cop0 && inst_rs(inst) == RS_MTC0;
    assign is_eret = is_cop0 && inst[CO_BIT] && inst_funct(inst) == FUNCT_ERET;
    assign rd      = inst_rd(inst);

    assign branch_to_handler = submit;
    assign eret              = is_eret & ~submit; // The handler jump wins over a return

    always_comb begin
        sr_entry              = sr;
        sr_entry[SR_EXL_BIT]  = 1'b1;
        sr_return             = sr;
        sr_return[SR_EXL_BIT] = 1'b0;
    end

    // Entry rewrites BD, the raw request lines and the code, other Cause bits keep their value
    always_comb begin
        cause_entry                                    = cause;
        cause_entry[CAUSE_BD_BIT]                      = bd;
        cause_entry[IP_MSB:IP_LSB]                     = irq;
        cause_entry[EXC_CODE_LSB +: $bits(exc_code_t)] = irq_pend ? EXC_INT : exc_code;
    end

    always_comb begin
        new_sr     = rt;
        sr_en      = 1'b0;
        new_cause  = cause_entry;
        cause_en   = 1'b0;
        new_epc    = rt;
        epc_en     = 1'b0;
        wr_count   = 1'b0;
        wr_compare = 1'b0;
        if (submit) begin
            new_sr   = sr_entry;
            sr_en    = 1'b1;
            cause_en = 1'b1;
            new_epc  = pc;
            epc_en   = 1'b1;
        end else if (is_eret) begin
            new_sr = sr_return;
            sr_en  = 1'b1;
        end else if (is_mtc0) begin
            // Writes to Cause fall through the case and are dropped
            case (rd)
                CP0_SR:      sr_en      = 1'b1;
                CP0_EPC:     epc_en     = 1'b1;
                CP0_COUNT:   wr_count   = 1'b1;
                CP0_COMPARE: wr_compare = 1'b1;
                default:     ;
            endcase
        end
    end

endmodule

// File: hdl/cp0_regs.sv
// Holds the SR, Cause and EPC registers of coprocessor 0 and returns register contents for mfc0
`timescale 1ns/1ns

module cp0_regs import cp0_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t inst,
    input  irq_t  irq,
    input  word_t new_sr,
    input  logic  sr_en,
    input  word_t new_cause,
    input  logic  cause_en,
    input  word_t new_epc,
    input  logic  epc_en,
    input  word_t count,
    input  word_t compare,
    output word_t sr,
    output word_t cause,
    output word_t epc,
    output word_t mfc0_data
);

    logic      is_mfc0;
    reg_addr_t rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            sr    <= '0;
            cause <= '0;
            epc   <= '0;
        end else begin
            if (sr_en) begin
                sr <= new_sr;
            end
            // Pending bits follow the request lines every cycle
            if (cause_en) begin
                cause <= new_cause;
            end else begin
                cause[IP_MSB:IP_LSB] <= irq;
            end
            if (epc_en) begin
                epc <= new_epc;
            end
        end
    end

    assign is_mfc0 = inst_op(inst) == OP_COP0 && inst_rs(inst) == RS_MFC0;
    assign rd      = inst_rd(inst);

    always_comb begin
        mfc0_data = '0;
        if (is_mfc0) begin
            case (rd)
                CP0_COUNT:   mfc0_data = count;
                CP0_COMPARE: mfc0_data = compare;
                CP0_SR:      mfc0_data = sr;
                CP0_CAUSE:   mfc0_data = cause;
                CP0_EPC:     mfc0_data = epc;
                default:     mfc0_data = '0; // Registers outside this subsystem read as zero
            endcase
        end
    end

endmodule

// File: hdl/cp0_timer.sv
// Count and Compare timer of coprocessor 0, raising a sticky interrupt when Count reaches Compare
`timescale 1ns/1ns

module cp0_timer import cp0_pkg::*; #(
    parameter int COUNT_DIV = COUNT_DIV_DEFAULT
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t rt,
    input  logic  wr_count,
    input  logic  wr_compare,
    output word_t count,
    output word_t compare,
    output logic  timer_irq
);

    // A divider of one still needs a one bit prescaler
    localparam int PRE_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(COUNT_DIV - 1);

    logic [PRE_W-1:0] prescale;
    logic             tick;

    assign tick = prescale == PRE_LAST;

    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
            count    <= '0;
        end else if (wr_count) begin
            prescale <= '0; // A new Count value starts a full period
            count    <= rt;
        end else if (tick) begin
            prescale <= '0;
            count    <= count + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            compare   <= '0;
            timer_irq <= 1'b0;
        end else if (wr_compare) begin
            compare   <= rt;
            timer_irq <= 1'b0; // Writing Compare acknowledges the interrupt
        end else if (count == compare) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

// File: hdl/cp0_top.sv
// Top level of the coprocessor 0 exception subsystem, connecting the submitter, registers and timer
`timescale 1ns/1ns

module cp0_top import cp0_pkg::*; #(
    parameter int COUNT_DIV = COUNT_DIV_DEFAULT
) (
    input  logic      clk,
    input  logic      rst,
    input  word_t     inst,
    input  word_t     rt,
    input  logic      exception,
    input  word_t     pc,
    input  exc_code_t exc_code,
    input  logic      bd,
    input  irq_t      int_req,
    output logic      branch_to_handler,
    output logic      eret,
    output word_t     epc,
    output word_t     mfc0_data,
    output logic      timer_irq
);

    irq_t  irq;
    word_t sr;
    word_t cause;
    word_t new_sr;
    word_t new_cause;
    word_t new_epc;
    logic  sr_en;
    logic  cause_en;
    logic  epc_en;
    logic  wr_count;
    logic  wr_compare;
    word_t count;
    word_t compare;

    assign irq = {int_req[5] | timer_irq, int_req[4:0]}; // Timer shares line 5, Cause bit 15

    cp0_submitter u_cp0_submitter (
        .inst              (inst),
        .rt                (rt),
        .exception         (exception),
        .pc                (pc),
        .exc_code          (exc_code),
        .bd                (bd),
        .irq               (irq),
        .sr                (sr),
        .cause             (cause),
        .branch_to_handler (branch_to_handler),
        .eret              (eret),
        .new_sr            (new_sr),
        .sr_en             (sr_en),
        .new_cause         (new_cause),
        .cause_en          (cause_en),
        .new_epc           (new_epc),
        .epc_en            (epc_en),
        .wr_count          (wr_count),
        .wr_compare        (wr_compare)
    );

    cp0_regs u_cp0_regs (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .irq       (irq),
        .new_sr    (new_sr),
        .sr_en     (sr_en),
        .new_cause (new_cause),
        .cause_en  (cause_en),
        .new_epc   (new_epc),
        .epc_en    (epc_en),
        .count     (count),
        .compare   (compare),
        .sr        (sr),
        .cause     (cause),
        .epc       (epc),
        .mfc0_data (mfc0_data)
    );

    cp0_timer #(
        .COUNT_DIV (COUNT_DIV)
    ) u_cp0_timer (
        .clk        (clk),
        .rst        (rst),
        .rt         (rt),
        .wr_count   (wr_count),
        .wr_compare (wr_compare),
        .count      (count),
        .compare    (compare),
        .timer_irq  (timer_irq)
    );

endmodule

// File: sim/cp0_top_assert.sv
// Concurrent checks on coprocessor 0 register updates, bound into every cp0_regs instance
`timescale 1ns/1ns

module cp0_top_assert (
    input logic        clk,
    input logic        rst,
    input logic [31:0] sr,
    input logic [31:0] epc,
    input logic [31:0] new_sr,
    input logic        sr_en,
    input logic        cause_en,
    input logic [31:0] new_epc,
    input logic        epc_en
);

    // Cause is written only on handler entry
    a_exl_after_entry: assert property (@(posedge clk) disable iff (rst) cause_en |=> sr[1])
        else $error("EXL not set after handler entry");

    a_no_bubble_entry: assert property (@(posedge clk) disable iff (rst)
        cause_en |-> new_epc != 32'h0)
        else $error("handler entry taken for a bubble");

    a_epc_hold: assert property (@(posedge clk) disable iff (rst) !epc_en |=> $stable(epc))
        else $error("EPC changed without a write enable");

    a_entry_keeps_exl: assert property (@(posedge clk) disable iff (rst)
        cause_en |-> sr_en && new_sr[1])
        else $error("handler entry would clear EXL");

endmodule

bind cp0_regs cp0_top_assert u_cp0_top_assert (
    .clk      (clk),
    .rst      (rst),
    .sr       (sr),
    .epc      (epc),
    .new_sr   (new_sr),
    .sr_en    (sr_en),
    .cause_en (cause_en),
    .new_epc  (new_epc),
    .epc_en   (epc_en)
);

// File: sim/cp0_top_tb.sv
// Testbench for the coprocessor 0 top level; reads sim/cp0_cases.txt and prints one line per case
`timescale 1ns/1ns

module cp0_top_tb;

    localparam int COUNT_DIV  = 2;
    localparam int TIMER_WAIT = 2000; // Cycles allowed for Count to reach Compare

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] rt;
    logic        exception;
    logic [31:0] pc;
    logic [4:0]  exc_code;
    logic        bd;
    logic [5:0]  int_req;
    logic        branch_to_handler;
    logic        eret;
    logic [31:0] epc;
    logic [31:0] mfc0_data;
    logic        timer_irq;

    integer seed   = 89;
    integer n_pass = 0;
    integer n_fail = 0;

    cp0_top #(
        .COUNT_DIV (COUNT_DIV)
    ) u_cp0_top (
        .clk               (clk),
        .rst               (rst),
        .inst              (inst),
        .rt                (rt),
        .exception         (exception),
        .pc                (pc),
        .exc_code          (exc_code),
        .bd                (bd),
        .int_req           (int_req),
        .branch_to_handler (branch_to_handler),
        .eret              (eret),
        .epc               (epc),
        .mfc0_data         (mfc0_data),
        .timer_irq         (timer_irq)
    );

    always #2 clk = ~clk;

    // COP0 move instruction with random filler in the rt field and low bits
    function automatic logic [31:0] cop0_word(input logic [4:0] rs, input logic [4:0] rd);
        logic [4:0]  rt_field;
        logic [10:0] low;
        rt_field = 5'($random(seed));
        low      = 11'($random(seed));
        return {6'b010000, rs, rt_field, rd, low};
    endfunction

    task automatic drive(input logic [31:0] i_inst, input logic [31:0] i_rt, input logic i_exc,
                         input logic [31:0] i_pc, input logic [4:0] i_code, input logic i_bd,
                         input logic [5:0] i_irq);
        @(posedge clk);
        inst      <= i_inst;
        rt        <= i_rt;
        exception <= i_exc;
        pc        <= i_pc;
        exc_code  <= i_code;
        bd        <= i_bd;
        int_req   <= i_irq;
        @(negedge clk); // Outputs are settled here
    endtask

    task automatic go_idle();
        drive(32'h0, 32'($random(seed)), 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %0s: expected %h, actual %h", name, expected, actual);
            n_fail++;
        end else begin
            $display("ok %0s: %h", name, actual);
            n_pass++;
        end
    endtask

    task automatic fail_case(input string name, input string why);
        $display("%0s: %0s", name, why);
        n_fail++;
    endtask

    task automatic run_case(input string name, input string op, input logic [4:0] rd,
                            input logic [31:0] data, input logic [31:0] c_pc,
                            input logic [4:0] code, input logic c_bd, input logic [5:0] c_irq,
                            input logic [31:0] expected);
        integer      waited;
        logic [31:0] rnd;
        rnd = $random(seed);
        if (op == "mtc0") begin
            drive(cop0_word(5'b00100, rd), data, 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
            go_idle();
            drive(cop0_word(5'b00000, rd), rnd, 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
            check_value(name, expected, mfc0_data);
        end else if (op == "mfc0") begin
            drive(cop0_word(5'b00000, rd), rnd, 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
            check_value(name, expected, mfc0_data);
        end else if (op == "exc" || op == "irq") begin
            // Opcode zero keeps the filler away from COP0 decoding
            drive({6'b000000, 26'($random(seed))}, rnd, op == "exc", c_pc, code, c_bd, c_irq);
            check_value(name, expected, {31'b0, branch_to_handler});
        end else if (op == "eret") begin
            drive(32'h42000018, rnd, 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
            if (eret !== 1'b1) begin
                fail_case(name, "eret was not raised for an eret instruction");
            end else begin
                check_value(name, expected, epc);
            end
        end else if (op == "timer") begin
            drive(cop0_word(5'b00100, 5'd11), data, 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
            go_idle();
            if (expected == 32'h0) begin
                check_value(name, expected, {31'b0, timer_irq});
            end else begin
                waited = 0;
                while (timer_irq !== 1'b1 && waited < TIMER_WAIT) begin
                    @(negedge clk);
                    waited++;
                end
                if (timer_irq !== 1'b1) begin
                    fail_case(name, "timer interrupt did not arrive before the timeout");
                end else begin
                    drive(32'h0, rnd, 1'b0, c_pc, 5'h0, 1'b0, 6'h0);
                    check_value(name, expected, {31'b0, branch_to_handler});
                end
            end
        end else begin
            fail_case(name, "unknown operation in the case file");
        end
        go_idle(); // One quiet edge lets Cause IP follow the idle request lines
    endtask

    initial begin
        integer      fd;
        integer      n;
        string       line;
        string       name;
        string       op;
        logic [31:0] rd;
        logic [31:0] data;
        logic [31:0] c_pc;
        logic [31:0] code;
        logic [31:0] c_bd;
        logic [31:0] c_irq;
        logic [31:0] expected;
        clk       = 1'b0;
        rst       = 1'b1;
        inst      = 32'h0;
        rt        = 32'h0;
        exception = 1'b0;
        pc        = 32'h0;
        exc_code  = 5'h0;
        bd        = 1'b0;
        int_req   = 6'h0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // Count and Compare both leave reset at zero and match at once
        drive(cop0_word(5'b00100, 5'd11), 32'hffffffff, 1'b0, 32'h0, 5'h0, 1'b0, 6'h0);
        go_idle();
        fd = $fopen("sim/cp0_cases.txt", "r");
        if (fd == 0) begin
            fail_case("setup", "cannot open sim/cp0_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h %h %h", name, op, rd, data, c_pc,
                                code, c_bd, c_irq, expected);
                    if (n != 9) begin
                        fail_case("parse", "a case line does not have nine columns");
                    end else begin
                        run_case(name, op, rd[4:0], data, c_pc, code[4:0], c_bd[0],
                                 c_irq[5:0], expected);
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim/cp0_cases.txt
# name op rd data pc code bd irq expected, all numbers in hex
# exc/irq expect branch_to_handler, eret expects epc, mtc0/mfc0 expect the read value
sr_enable_ie       mtc0  0c 00000401 00000000 00 0 00 00000401
exc_entry          exc   00 00000000 00400100 0c 1 00 00000001
exc_epc            mfc0  0e 00000000 00000000 00 0 00 00400100
exc_cause          mfc0  0d 00000000 00000000 00 0 00 80000030
exc_sr_exl         mfc0  0c 00000000 00000000 00 0 00 00000403
irq_blocked_exl    irq   00 00000000 00400200 00 0 01 00000000
eret_return        eret  00 00000000 00000000 00 0 00 00400100
eret_sr            mfc0  0c 00000000 00000000 00 0 00 00000401
irq_masked         irq   00 00000000 00400200 00 0 02 00000000
irq_taken          irq   00 00000000 00400300 00 0 01 00000001
irq_cause_code     mfc0  0d 00000000 00000000 00 0 00 00000000
irq_epc            mfc0  0e 00000000 00000000 00 0 00 00400300
eret_after_irq     eret  00 00000000 00000000 00 0 00 00400300
bubble_exc         exc   00 00000000 00000000 0a 0 00 00000000
bubble_epc         mfc0  0e 00000000 00000000 00 0 00 00400300
epc_write          mtc0  0e 12345678 00000000 00 0 00 12345678
cause_write        mtc0  0d ffffffff 00000000 00 0 00 00000000
sr_timer_mask      mtc0  0c 00008001 00000000 00 0 00 00008001
timer_set          timer 0b 00000100 00400400 00 0 00 00000001
timer_clear        timer 0b 7fffffff 00000000 00 0 00 00000000

// File: cp0_top.f
hdl/cp0_pkg.sv
hdl/cp0_submitter.sv
hdl/cp0_regs.sv
hdl/cp0_timer.sv
hdl/cp0_top.sv
sim/cp0_top_assert.sv
sim/cp0_top_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = cp0_top_tb
FLIST = cp0_top.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
